/* src/defines.sv */
// Shared widths, instruction fields and select encodings for the decode front end, compiled first.

package defines;

	// ==================================================
	// Machine words
	// ==================================================

	// Register width of the RV32I base ISA.
	localparam int XLEN = 32;

	// One machine word. PCs, operands and jump targets all use it.
	typedef logic [XLEN-1:0] data_t;

	// One fetched instruction word.
	// The opcode sits in bits 6:0, funct3 in bits 14:12.
	// The rs1 field is bits 19:15 and the rs2 field is bits 24:20.
	typedef logic [31:0] instr_t;

	// Decoded instruction fields.
	typedef logic [6:0] opcode_t;
	typedef logic [2:0] funct3_t;
	typedef logic [4:0] reg_addr_t;

	// All-zero word, used as the fallback for muxes and immediates.
	localparam data_t NULL = '0;

	// Sequential PC increment for a 32-bit instruction.
	localparam data_t PC_STEP = data_t'(4);

	// ==================================================
	// Major opcodes
	// ==================================================

	// Conditional branches.
	localparam opcode_t B = 7'b1100011;
	// Jump and link, PC relative.
	localparam opcode_t JAL = 7'b1101111;
	// Jump and link, register relative.
	localparam opcode_t JALR = 7'b1100111;
	// Register-immediate ALU operations.
	localparam opcode_t OP_IMM = 7'b0010011;
	// Register-register ALU operations.
	localparam opcode_t OP = 7'b0110011;

	// Branch conditions carried in funct3 of a B-type instruction.
	// The codes 010 and 011 are not branches and never take.
	localparam funct3_t BEQ = 3'b000;
	localparam funct3_t BNE = 3'b001;
	localparam funct3_t BLT = 3'b100;
	localparam funct3_t BGE = 3'b101;
	localparam funct3_t BLTU = 3'b110;
	localparam funct3_t BGEU = 3'b111;

	// ==================================================
	// Select and state encodings
	// ==================================================

	// Where a decode operand comes from.
	// RS_ID_SEL is the register file value, the others are in-flight results.
	typedef enum logic [1:0] {
		RS_ID_SEL = 2'd0,
		EX_ID_SEL = 2'd1,
		MEM_ID_SEL = 2'd2,
		WB_ID_SEL = 2'd3
	} id_fwd_sel_t;

	// Fetch handshake states.
	// IDLE waits for ack low, REQ holds req, DROP waits for ack to fall.
	// HOLD keeps the instruction for decode once the memory has let go.
	typedef enum logic [1:0] {
		IDLE = 2'd0,
		REQ = 2'd1,
		DROP = 2'd2,
		HOLD = 2'd3
	} fetch_state_t;

endpackage : defines

/* src/id_forward_unit.sv */
// Decode operand forwarding; picks the youngest pending EX/MEM/WB write for each register source.

`timescale 1ns/10ps

module id_forward_unit (
	input	defines::reg_addr_t		rs1_addr,
	input	defines::reg_addr_t		rs2_addr,
	input	defines::reg_addr_t		ex_rd,
	input	defines::reg_addr_t		mem_rd,
	input	defines::reg_addr_t		wb_rd,
	input	logic					ex_we,
	input	logic					mem_we,
	input	logic					wb_we,

	output	defines::id_fwd_sel_t	fwd_rs1,
	output	defines::id_fwd_sel_t	fwd_rs2
);

	// ==================================================
	// Per-source priority encoder
	// ==================================================

	// Returns the operand source for one register read.
	// EX holds the youngest result, so it wins over MEM, and MEM over WB.
	// A stage only counts when it really writes and its target is not x0.
	function automatic defines::id_fwd_sel_t pick_source(
		input defines::reg_addr_t	src,
		input defines::reg_addr_t	ex_tag,
		input logic					ex_wr,
		input defines::reg_addr_t	mem_tag,
		input logic					mem_wr,
		input defines::reg_addr_t	wb_tag,
		input logic					wb_wr
	);
		defines::id_fwd_sel_t sel;

		sel = defines::RS_ID_SEL;

		// Register zero reads as zero, whatever is in flight for it.
		if (src != '0) begin
			if (ex_wr && (ex_tag == src)) begin
				sel = defines::EX_ID_SEL;
			end else if (mem_wr && (mem_tag == src)) begin
				sel = defines::MEM_ID_SEL;
			end else if (wb_wr && (wb_tag == src)) begin
				sel = defines::WB_ID_SEL;
			end
		end

		return sel;
	endfunction

	// ==================================================
	// Select outputs
	// ==================================================

	// Both sources use the same encoder against the same three stages.
	// The selects are purely combinational and follow id_instr directly.
	always_comb begin
		fwd_rs1 = pick_source(rs1_addr, ex_rd, ex_we, mem_rd, mem_we, wb_rd, wb_we);
		fwd_rs2 = pick_source(rs2_addr, ex_rd, ex_we, mem_rd, mem_we, wb_rd, wb_we);
	end

endmodule : id_forward_unit

/* src/pc_adder.sv */
// Decode-stage branch and jump resolution; gives the taken flag, the target and the next fetch PC.

`timescale 1ns/10ps

module pc_adder (
	input	defines::instr_t		instr,
	input	defines::data_t			pc,
	input	defines::data_t			rs1,
	input	defines::data_t			rs2,
	input	defines::data_t			ex_data,
	input	defines::data_t			mem_data,
	input	defines::data_t			wb_data,
	input	defines::id_fwd_sel_t	fwd_rs1,
	input	defines::id_fwd_sel_t	fwd_rs2,

	output	defines::data_t			pc_bj,
	output	defines::data_t			pc_nxt,
	output	logic					pc_sel,
	output	logic					branch_taken
);

	defines::opcode_t	opcode;
	defines::funct3_t	funct3;
	defines::data_t		op1;
	defines::data_t		op2;
	defines::data_t		imm;
	defines::data_t		base;
	defines::data_t		target;
	logic				is_branch;
	logic				is_jal;
	logic				is_jalr;
	logic				cond;

	// Field decode. Only the opcode and funct3 matter for control flow.
	assign opcode = instr[6:0];
	assign funct3 = instr[14:12];

	assign is_branch = (opcode == defines::B);
	assign is_jal = (opcode == defines::JAL);
	assign is_jalr = (opcode == defines::JALR);

	// ==================================================
	// Operand forwarding mux
	// ==================================================

	// Returns the register file value or the in-flight result named by sel.
	function automatic defines::data_t pick_operand(
		input defines::id_fwd_sel_t	sel,
		input defines::data_t		rf_value,
		input defines::data_t		ex_value,
		input defines::data_t		mem_value,
		input defines::data_t		wb_value
	);
		defines::data_t value;

		case (sel)
			defines::RS_ID_SEL:		value = rf_value;
			defines::EX_ID_SEL:		value = ex_value;
			defines::MEM_ID_SEL:	value = mem_value;
			defines::WB_ID_SEL:		value = wb_value;
			default:				value = defines::NULL;
		endcase

		return value;
	endfunction

	assign op1 = pick_operand(fwd_rs1, rs1, ex_data, mem_data, wb_data);
	assign op2 = pick_operand(fwd_rs2, rs2, ex_data, mem_data, wb_data);

	// ==================================================
	// Branch condition
	// ==================================================

	// The six conditions come in pairs, each one the inverse of the other.
	// Only a B-type opcode may raise branch_taken.
	always_comb begin
		case (funct3)
			defines::BEQ:	cond = (op1 == op2);
			defines::BNE:	cond = (op1 != op2);
			defines::BLT:	cond = ($signed(op1) < $signed(op2));
			defines::BGE:	cond = ($signed(op1) >= $signed(op2));
			defines::BLTU:	cond = (op1 < op2);
			defines::BGEU:	cond = (op1 >= op2);
			default:		cond = 1'b0;
		endcase
	end

	assign branch_taken = is_branch && cond;

	// ==================================================
	// Immediate and target
	// ==================================================

	// B and J offsets are in half-words, so bit 0 is a zero filler.
	// The JALR offset is a plain signed byte offset from the I format.
	always_comb begin
		case (opcode)
			defines::B:		imm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
			defines::JAL:	imm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
			defines::JALR:	imm = {{20{instr[31]}}, instr[31:20]};
			default:		imm = defines::NULL;
		endcase
	end

	// JALR adds to the forwarded rs1; branches and JAL add to the PC.
	assign base = is_jalr ? op1 : pc;
	assign target = base + imm;

	// The JALR result has its lowest bit forced to zero.
	assign pc_bj = is_jalr ? {target[defines::XLEN-1:1], 1'b0} : target;

	// Redirect on a taken branch or on any jump, otherwise step on.
	assign pc_sel = branch_taken || is_jal || is_jalr;
	assign pc_nxt = pc_sel ? pc_bj : (pc + defines::PC_STEP);

endmodule : pc_adder

/* src/fetch_unit.sv */
// Fetch PC and four-phase instruction-memory handshake; hands each word to decode and waits for accept.

`timescale 1ns/10ps

module fetch_unit #(
	parameter defines::data_t RESET_PC = 32'h0000_0000
) (
	input	logic				clk,
	input	logic				reset,
	input	logic				id_stall,
	input	defines::data_t		pc_nxt,

	output	logic				imem_req,
	output	defines::data_t		imem_addr,
	input	logic				imem_ack,
	input	defines::instr_t	imem_rdata,

	output	logic				id_valid,
	output	defines::instr_t	id_instr,
	output	defines::data_t		id_pc
);

	defines::fetch_state_t	state;
	defines::fetch_state_t	state_nxt;
	defines::data_t			pc;
	logic					capture;
	logic					accept;

	// ==================================================
	// Handshake and decode strobes
	// ==================================================

	// Req is high exactly while the FSM sits in REQ.
	// The address is the PC register, which only moves on acceptance.
	assign imem_req = (state == defines::REQ);
	assign imem_addr = pc;

	// The word is taken in the cycle the memory acknowledges.
	assign capture = (state == defines::REQ) && imem_ack;

	// An instruction is held for decode in DROP and in HOLD.
	// Decode takes it in any cycle it is not stalled.
	assign id_valid = (state == defines::DROP) || (state == defines::HOLD);
	assign accept = id_valid && !id_stall;

	// ==================================================
	// Fetch FSM
	// ==================================================

	// A new request never starts while ack is still high from the last one.
	// There is no prefetch, so the next request waits for the accepted pc_nxt.
	always_comb begin
		state_nxt = state;
		unique case (state)
			defines::IDLE: begin
				if (!imem_ack) begin
					state_nxt = defines::REQ;
				end
			end
			defines::REQ: begin
				if (imem_ack) begin
					state_nxt = defines::DROP;
				end
			end
			defines::DROP: begin
				// Acceptance may come before the memory has dropped ack.
				if (accept) begin
					state_nxt = imem_ack ? defines::IDLE : defines::REQ;
				end else if (!imem_ack) begin
					state_nxt = defines::HOLD;
				end
			end
			defines::HOLD: begin
				if (accept) begin
					state_nxt = imem_ack ? defines::IDLE : defines::REQ;
				end
			end
			default: begin
				state_nxt = defines::IDLE;
			end
		endcase
	end

	// State and PC. The PC steps or redirects only when decode takes the word.
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= defines::IDLE;
			pc <= RESET_PC;
		end else begin
			state <= state_nxt;
			if (accept) begin
				pc <= pc_nxt;
			end
		end
	end

	// ==================================================
	// Decode holding registers
	// ==================================================

	// The word and the address it came from are kept until acceptance.
	// Both stay put through a stall because capture only fires in REQ.
	always_ff @(posedge clk) begin
		if (capture) begin
			id_instr <= imem_rdata;
			id_pc <= pc;
		end
	end

endmodule : fetch_unit

/* src/branch_frontend.sv */
// Top of the decode control-flow front end; wires fetch, operand forwarding and branch resolution.

`timescale 1ns/10ps

module branch_frontend #(
	parameter defines::data_t RESET_PC = 32'h0000_0000
) (
	input	logic					clk,
	input	logic					reset,

	// Instruction memory port.
	output	logic					imem_req,
	output	defines::data_t			imem_addr,
	input	logic					imem_ack,
	input	defines::instr_t		imem_rdata,

	// Decode side.
	input	logic					id_stall,
	output	logic					id_valid,
	output	defines::instr_t		id_instr,
	output	defines::data_t			id_pc,

	// Register file reads, answered in the same cycle.
	output	defines::reg_addr_t		rs1_addr,
	output	defines::reg_addr_t		rs2_addr,
	input	defines::data_t			rs1_data,
	input	defines::data_t			rs2_data,

	// Pending writes from the later stages.
	input	defines::reg_addr_t		ex_rd,
	input	logic					ex_we,
	input	defines::data_t			ex_data,
	input	defines::reg_addr_t		mem_rd,
	input	logic					mem_we,
	input	defines::data_t			mem_data,
	input	defines::reg_addr_t		wb_rd,
	input	logic					wb_we,
	input	defines::data_t			wb_data,

	// Control-flow result.
	output	logic					pc_sel,
	output	logic					branch_taken,
	output	defines::data_t			pc_bj
);

	defines::data_t			pc_nxt;
	defines::id_fwd_sel_t	fwd_rs1;
	defines::id_fwd_sel_t	fwd_rs2;

	// Source register numbers straight from the held instruction.
	assign rs1_addr = id_instr[19:15];
	assign rs2_addr = id_instr[24:20];

	fetch_unit #(
		.RESET_PC	(RESET_PC)
	) u_fetch_unit (
		.clk		(clk),
		.reset		(reset),
		.id_stall	(id_stall),
		.pc_nxt		(pc_nxt),
		.imem_req	(imem_req),
		.imem_addr	(imem_addr),
		.imem_ack	(imem_ack),
		.imem_rdata	(imem_rdata),
		.id_valid	(id_valid),
		.id_instr	(id_instr),
		.id_pc		(id_pc)
	);

	id_forward_unit u_id_forward_unit (
		.rs1_addr	(rs1_addr),
		.rs2_addr	(rs2_addr),
		.ex_rd		(ex_rd),
		.mem_rd		(mem_rd),
		.wb_rd		(wb_rd),
		.ex_we		(ex_we),
		.mem_we		(mem_we),
		.wb_we		(wb_we),
		.fwd_rs1	(fwd_rs1),
		.fwd_rs2	(fwd_rs2)
	);

	// The next PC goes back to fetch in the same cycle, with no register.
	pc_adder u_pc_adder (
		.instr			(id_instr),
		.pc				(id_pc),
		.rs1			(rs1_data),
		.rs2			(rs2_data),
		.ex_data		(ex_data),
		.mem_data		(mem_data),
		.wb_data		(wb_data),
		.fwd_rs1		(fwd_rs1),
		.fwd_rs2		(fwd_rs2),
		.pc_bj			(pc_bj),
		.pc_nxt			(pc_nxt),
		.pc_sel			(pc_sel),
		.branch_taken	(branch_taken)
	);

endmodule : branch_frontend

/* testbench/tb_imem_responder.sv */
// Instruction memory stand-in for simulation; answers four-phase fetch requests with random words.

`timescale 1ns/10ps

module tb_imem_responder (
	input	logic				clk,
	input	logic				reset,
	input	logic				req,
	input	defines::data_t		addr,

	output	logic				ack,
	output	defines::instr_t	rdata,
	output	defines::data_t		last_addr,
	output	defines::instr_t	last_word
);

	// Builds one random instruction from the branch, jump and ALU mix.
	// Sources are drawn from x0 to x3 so they often meet the stage tags.
	function automatic defines::instr_t random_instr();
		defines::instr_t	word;
		int					kind;
		int					cond;

		word = $urandom();
		kind = $urandom_range(0, 5);
		cond = $urandom_range(0, 5);
		word[19:15] = $urandom_range(0, 3);
		word[24:20] = $urandom_range(0, 3);
		case (kind)
			0, 1: begin
				word[6:0] = defines::B;
				// Maps 0..5 onto the six real conditions, skipping 010 and 011.
				word[14:12] = (cond < 2) ? cond : cond + 2;
			end
			2:			word[6:0] = defines::JAL;
			3:			word[6:0] = defines::JALR;
			4:			word[6:0] = defines::OP_IMM;
			default:	word[6:0] = defines::OP;
		endcase
		return word;
	endfunction

	// ==================================================
	// Four-phase responder
	// ==================================================

	// All outputs move 1 ns after the rising edge, like the other stimulus.
	// Ack may also linger for a few cycles after req falls.
	initial begin
		int		delay;
		logic	pending;
		int		release_wait;
		logic	releasing;

		ack = 1'b0;
		rdata = '0;
		last_addr = '0;
		last_word = '0;
		delay = 0;
		pending = 1'b0;
		release_wait = 0;
		releasing = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			if (reset) begin
				ack = 1'b0;
				pending = 1'b0;
				releasing = 1'b0;
			end else if (req && !ack) begin
				// A fresh request draws its own wait of 0 to 3 cycles.
				if (!pending) begin
					pending = 1'b1;
					delay = $urandom_range(0, 3);
				end
				if (delay == 0) begin
					rdata = random_instr();
					last_addr = addr;
					last_word = rdata;
					ack = 1'b1;
					pending = 1'b0;
				end else begin
					delay = delay - 1;
				end
			end else if (ack && !req) begin
				// The release of ack waits 0 to 2 cycles.
				if (!releasing) begin
					releasing = 1'b1;
					release_wait = $urandom_range(0, 2);
				end
				if (release_wait == 0) begin
					ack = 1'b0;
					releasing = 1'b0;
				end else begin
					release_wait = release_wait - 1;
				end
			end
		end
	end

endmodule : tb_imem_responder

/* testbench/tb_branch_frontend.sv */
// Testbench top for the decode front end; random fetch, stall and forwarding traffic against a model.

`timescale 1ns/10ps

module tb_branch_frontend;

	localparam defines::data_t RESET_PC = 32'h0000_1000;
	localparam int N_INSTR = 400;
	localparam int MAX_CYCLES = N_INSTR * 12;

	logic				clk;
	logic				reset;
	logic				id_stall;
	logic				imem_req;
	logic				imem_ack;
	logic				id_valid;
	logic				pc_sel;
	logic				branch_taken;
	logic				ex_we;
	logic				mem_we;
	logic				wb_we;
	defines::data_t		imem_addr;
	defines::data_t		id_pc;
	defines::data_t		pc_bj;
	defines::data_t		rs1_data;
	defines::data_t		rs2_data;
	defines::data_t		ex_data;
	defines::data_t		mem_data;
	defines::data_t		wb_data;
	defines::data_t		last_addr;
	defines::instr_t	imem_rdata;
	defines::instr_t	id_instr;
	defines::instr_t	last_word;
	defines::reg_addr_t	rs1_addr;
	defines::reg_addr_t	rs2_addr;
	defines::reg_addr_t	ex_rd;
	defines::reg_addr_t	mem_rd;
	defines::reg_addr_t	wb_rd;
	int errors = 0;
	int checks = 0;
	int accepted = 0;
	int cycles = 0;

	branch_frontend #(.RESET_PC(RESET_PC)) uut (
		.clk(clk),
		.reset(reset),
		.imem_req(imem_req),
		.imem_addr(imem_addr),
		.imem_ack(imem_ack),
		.imem_rdata(imem_rdata),
		.id_stall(id_stall),
		.id_valid(id_valid),
		.id_instr(id_instr),
		.id_pc(id_pc),
		.rs1_addr(rs1_addr),
		.rs2_addr(rs2_addr),
		.rs1_data(rs1_data),
		.rs2_data(rs2_data),
		.ex_rd(ex_rd),
		.ex_we(ex_we),
		.ex_data(ex_data),
		.mem_rd(mem_rd),
		.mem_we(mem_we),
		.mem_data(mem_data),
		.wb_rd(wb_rd),
		.wb_we(wb_we),
		.wb_data(wb_data),
		.pc_sel(pc_sel),
		.branch_taken(branch_taken),
		.pc_bj(pc_bj)
	);

	tb_imem_responder u_imem (
		.clk(clk),
		.reset(reset),
		.req(imem_req),
		.addr(imem_addr),
		.ack(imem_ack),
		.rdata(imem_rdata),
		.last_addr(last_addr),
		.last_word(last_word)
	);

	// ==================================================
	// Checking helpers and reference model
	// ==================================================

	task automatic expect_equal(input defines::data_t got, input defines::data_t exp,
			input string what);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic expect_rule(input logic ok, input string what);
		checks++;
		assert (ok === 1'b1) else begin
			errors++;
			$display("Protocol error at %0t ns: %s", $time, what);
		end
	endtask

	// Operand seen by decode. Older stages are applied first, so a younger match overrides.
	function automatic defines::data_t fwd_value(input defines::reg_addr_t src,
			input defines::data_t rf_value);
		defines::data_t value;

		value = rf_value;
		if (src != 5'd0) begin
			if (wb_we && (wb_rd == src)) value = wb_data;
			if (mem_we && (mem_rd == src)) value = mem_data;
			if (ex_we && (ex_rd == src)) value = ex_data;
		end
		return value;
	endfunction

	function automatic logic branch_cond(input defines::funct3_t f3, input defines::data_t a,
			input defines::data_t b);
		case (f3)
			defines::BEQ:	return a == b;
			defines::BNE:	return a != b;
			defines::BLT:	return $signed(a) < $signed(b);
			defines::BGE:	return !($signed(a) < $signed(b));
			defines::BLTU:	return a < b;
			defines::BGEU:	return !(a < b);
			default:		return 1'b0;
		endcase
	endfunction

	// Target of a branch or jump, with the offset rebuilt from the scattered fields.
	function automatic defines::data_t jump_target(input defines::instr_t i,
			input defines::data_t pc, input defines::data_t a);
		logic [12:0] b_off;
		logic [20:0] j_off;
		logic [11:0] i_off;

		b_off = {i[31], i[7], i[30:25], i[11:8], 1'b0};
		j_off = {i[31], i[19:12], i[20], i[30:21], 1'b0};
		i_off = i[31:20];
		case (i[6:0])
			defines::B:		return pc + {{19{b_off[12]}}, b_off};
			defines::JAL:	return pc + {{11{j_off[20]}}, j_off};
			defines::JALR:	return (a + {{20{i_off[11]}}, i_off}) & ~32'd1;
			default:		return pc;
		endcase
	endfunction

	// Small values half the time, so equal and ordered operands both show up.
	function automatic defines::data_t pick_data();
		return ($urandom_range(0, 1) == 0) ? $urandom_range(0, 3) : $urandom();
	endfunction

	// ==================================================
	// Clock, reset and pipeline stand-in
	// ==================================================

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		void'($urandom(32'hf6556c6e));
		{reset, id_stall, ex_we, mem_we, wb_we} = 5'b10000;
		{rs1_data, rs2_data, ex_data, mem_data, wb_data} = '0;
		{ex_rd, mem_rd, wb_rd} = '0;
		repeat (8) @(posedge clk);
		#1 reset = 1'b0;
		forever begin
			@(posedge clk);
			#1;
			// Roughly one cycle in four is stalled by the later stages.
			id_stall = ($urandom_range(0, 3) == 0);
			rs1_data = pick_data();
			rs2_data = pick_data();
			ex_data = pick_data();
			mem_data = pick_data();
			wb_data = pick_data();
			ex_rd = $urandom_range(0, 3);
			mem_rd = $urandom_range(0, 3);
			wb_rd = $urandom_range(0, 3);
			{ex_we, mem_we, wb_we} = $urandom_range(0, 7);
		end
	end

	// ==================================================
	// Monitor, sampled at the falling edge
	// ==================================================

	initial begin
		logic				req_prev;
		logic				ack_prev;
		logic				valid_prev;
		logic				stall_prev;
		logic				exp_taken;
		logic				exp_sel;
		defines::data_t		addr_prev;
		defines::data_t		pc_prev;
		defines::data_t		expected_addr;
		defines::data_t		op1;
		defines::data_t		op2;
		defines::data_t		target;
		defines::instr_t	instr_prev;

		{req_prev, ack_prev, valid_prev, stall_prev} = '0;
		{addr_prev, pc_prev, instr_prev} = '0;
		expected_addr = RESET_PC;
		while ((accepted < N_INSTR) && (cycles < MAX_CYCLES)) begin
			@(negedge clk);
			cycles++;
			if (reset) begin
				expect_rule(!imem_req && !id_valid, "req or id_valid high during reset");
			end else begin
				// A new request must wait for ack low and use the redirected PC.
				if (imem_req && !req_prev) begin
					expect_rule(!ack_prev, "req rose while ack was still high");
					expect_equal(imem_addr, expected_addr, "request address");
				end
				if (imem_req && req_prev) expect_equal(imem_addr, addr_prev, "held imem_addr");
				// A stalled instruction stays valid until decode takes it.
				if (valid_prev && stall_prev) begin
					expect_rule(id_valid, "id_valid dropped while decode was stalled");
				end
				if (id_valid) begin
					expect_rule(!imem_req, "request issued while an instruction is held");
					expect_equal(id_instr, last_word, "id_instr vs returned word");
					expect_equal(id_pc, last_addr, "id_pc vs fetched address");
					// Register reads name the source fields of the returned word.
					expect_equal(rs1_addr, last_word[19:15], "rs1_addr");
					expect_equal(rs2_addr, last_word[24:20], "rs2_addr");
					if (valid_prev && stall_prev) begin
						expect_equal(id_instr, instr_prev, "id_instr through stall");
						expect_equal(id_pc, pc_prev, "id_pc through stall");
					end
					op1 = fwd_value(id_instr[19:15], rs1_data);
					op2 = fwd_value(id_instr[24:20], rs2_data);
					exp_taken = (id_instr[6:0] == defines::B)
						&& branch_cond(id_instr[14:12], op1, op2);
					exp_sel = exp_taken || (id_instr[6:0] == defines::JAL)
						|| (id_instr[6:0] == defines::JALR);
					target = jump_target(id_instr, id_pc, op1);
					expect_equal(branch_taken, exp_taken, "branch_taken");
					expect_equal(pc_sel, exp_sel, "pc_sel");
					if (exp_sel) expect_equal(pc_bj, target, "pc_bj");
					// Acceptance happens at the coming edge, so the next fetch is set now.
					if (!id_stall) begin
						expected_addr = exp_sel ? target : id_pc + 32'd4;
						accepted++;
					end
				end
			end
			{req_prev, ack_prev, valid_prev, stall_prev} = {imem_req, imem_ack, id_valid, id_stall};
			{addr_prev, pc_prev, instr_prev} = {imem_addr, id_pc, id_instr};
		end
		if (accepted < N_INSTR) begin
			$display("Timeout: the run hung after %0d cycles with %0d instructions accepted",
				cycles, accepted);
		end
		$display("Accepted %0d instructions, ran %0d checks, found %0d errors",
			accepted, checks, errors);
		if ((errors == 0) && (accepted >= N_INSTR)) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule : tb_branch_frontend

/* rv_branch.f */
src/defines.sv
src/id_forward_unit.sv
src/pc_adder.sv
src/fetch_unit.sv
src/branch_frontend.sv
testbench/tb_imem_responder.sv
testbench/tb_branch_frontend.sv

/* Bender.yml */
package:
  name: rv_branch

sources:
  # Package first, then the RTL from the leaves up to the top level.
  - src/defines.sv
  - src/id_forward_unit.sv
  - src/pc_adder.sv
  - src/fetch_unit.sv
  - src/branch_frontend.sv

  - target: test
    files:
      - testbench/tb_imem_responder.sv
      - testbench/tb_branch_frontend.sv
